//--- Bender.yml
package:
  name: rom_subsys

sources:
  - files:
      - source/rom_types_pkg.sv
      - source/rom_arb_pkg.sv
      - source/dl_packer.sv
      - source/rom_store.sv
      - source/rom_slot_arb.sv
      - source/rom_subsys.sv
  - target: simulation
    files:
      - dv/rom_subsys_sva.sv
      - dv/rom_checker.sv
      - dv/tb_rom_subsys.sv

//--- dv/rom_checker.sv
module rom_checker
    import rom_types_pkg::*;
#(
    parameter bit SWAB       = 1'b0,
    parameter int GFX_OFFSET = 0,
    parameter int SND_OFFSET = 2048,
    parameter int GFX_AW     = 11,
    parameter int SND_AW     = 11,
    parameter int IMG_BYTES  = 8192
) (
    input  logic              clk,
    input  logic              arst_n,
    input  byte_t             image [0:IMG_BYTES-1],
    input  logic              gfx_cs,
    input  logic [GFX_AW-1:0] gfx_addr,
    input  word_t             gfx_data,
    input  logic              gfx_ok,
    input  logic              snd_cs,
    input  logic [SND_AW-1:0] snd_addr,
    input  byte_t             snd_data,
    input  logic              snd_ok,
    output int                errors,
    output int                compares
);
    timeunit 1ns;
    timeprecision 100ps;

    // Request as seen on the edge that produced the current ok
    logic              gfx_cs_q, snd_cs_q;
    logic [GFX_AW-1:0] gfx_addr_q;
    logic [SND_AW-1:0] snd_addr_q;
    word_t             gfx_exp, snd_exp;

    // Word as the download order places it
    function automatic word_t stored_word(input int waddr);
        byte_t even_b;
        byte_t odd_b;
        even_b = image[2 * waddr];
        odd_b  = image[2 * waddr + 1];
        return SWAB ? {even_b, odd_b} : {odd_b, even_b};
    endfunction

    // Expected slot data, sound byte zero extended
    function automatic word_t expected_data(input bit is_snd, input int addr);
        word_t w;
        if (!is_snd) begin
            return stored_word(GFX_OFFSET + addr);
        end
        w = stored_word(SND_OFFSET + addr / 2);
        // Even byte is the low half unless swapped
        if ((addr % 2 == 0) ^ SWAB) begin
            return {8'h00, w[7:0]};
        end
        return {8'h00, w[15:8]};
    endfunction

    initial begin
        errors   = 0;
        compares = 0;
    end

    always @(posedge clk) begin
        if (arst_n && gfx_ok && gfx_cs_q) begin
            compares++;
            gfx_exp = expected_data(1'b0, int'(gfx_addr_q));
            if (gfx_data !== gfx_exp) begin
                $display("ERROR %0t gfx_data expected %h actual %h", $time, gfx_exp, gfx_data);
                errors++;
            end
        end
        if (arst_n && snd_ok && snd_cs_q) begin
            compares++;
            snd_exp = expected_data(1'b1, int'(snd_addr_q));
            if (snd_data !== snd_exp[7:0]) begin
                $display("ERROR %0t snd_data expected %h actual %h", $time, snd_exp[7:0],
                         snd_data);
                errors++;
            end
        end
        gfx_cs_q   <= gfx_cs;
        gfx_addr_q <= gfx_addr;
        snd_cs_q   <= snd_cs;
        snd_addr_q <= snd_addr;
    end

endmodule

//--- dv/rom_subsys_sva.sv
module rom_subsys_sva (
    input logic clk,
    input logic arst_n,
    input logic downloading,
    input logic prog_we,
    input logic rd_en,
    input logic gfx_ok,
    input logic snd_ok
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // Word write is a single-cycle pulse
    a_prog_we_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        prog_we |=> !prog_we)
        else begin
            $error("prog_we stayed high for more than one cycle");
            fail_count++;
        end

    // ok and rd_en are registered, so they follow downloading one cycle late
    a_ok_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        $past(downloading) |-> !gfx_ok && !snd_ok)
        else begin
            $error("a slot ok level was high during a download");
            fail_count++;
        end

    a_no_read: assert property (@(posedge clk) disable iff (!arst_n)
        $past(downloading) |-> !rd_en)
        else begin
            $error("rd_en was high during a download");
            fail_count++;
        end

endmodule

bind rom_subsys rom_subsys_sva i_sva (
    .clk         ( clk         ),
    .arst_n      ( arst_n      ),
    .downloading ( downloading ),
    .prog_we     ( prog_we     ),
    .rd_en       ( rd_en       ),
    .gfx_ok      ( gfx_ok      ),
    .snd_ok      ( snd_ok      )
);

//--- dv/tb_rom_subsys.sv
module tb_rom_subsys
    import rom_types_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam bit SWAB       = 1'b1;
    localparam int GFX_OFFSET = 0;
    localparam int SND_OFFSET = 2048;
    localparam int GFX_AW     = 11;
    localparam int SND_AW     = 11;
    localparam int IMG_BYTES  = 1 << $bits(dl_addr_t);
    localparam int CLK_PERIOD = 40;
    localparam int N_RAND     = 256;                  // Random requests per phase
    localparam int DL_CYCLES  = 2 * IMG_BYTES + 8;    // Idle gaps at most double it
    localparam int N_REQ      = (1 << GFX_AW) + 10 * N_RAND + 4;
    localparam int TIMEOUT_NS = 2 * (2 * DL_CYCLES + 12 * N_REQ) * CLK_PERIOD;

    logic              clk, arst_n, downloading, ioctl_wr;
    dl_addr_t          ioctl_addr;
    byte_t             ioctl_dout, snd_data;
    word_t             gfx_data;
    logic              gfx_cs, gfx_ok, snd_cs, snd_ok;
    logic [GFX_AW-1:0] gfx_addr;
    logic [SND_AW-1:0] snd_addr;
    byte_t             image [0:IMG_BYTES-1];
    logic [31:0]       rnd;
    int                gfx_cycles, snd_cycles, tb_errors, chk_errors, chk_compares, total;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    rom_subsys #(.SWAB(SWAB), .GFX_OFFSET(GFX_OFFSET), .SND_OFFSET(SND_OFFSET),
                 .GFX_AW(GFX_AW), .SND_AW(SND_AW)) i_dut (.*);

    rom_checker #(.SWAB(SWAB), .GFX_OFFSET(GFX_OFFSET), .SND_OFFSET(SND_OFFSET),
                  .GFX_AW(GFX_AW), .SND_AW(SND_AW), .IMG_BYTES(IMG_BYTES)) i_checker (
        .*,
        .errors   ( chk_errors   ),
        .compares ( chk_compares )
    );

    // Inputs change 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic download_image();
        downloading = 1'b1;
        next_cycle();   // ok drops one cycle after downloading rises
        next_cycle();
        for (int i = 0; i < IMG_BYTES; i++) begin
            image[i] = byte_t'($urandom);
        end
        for (int i = 0; i < IMG_BYTES; i++) begin
            ioctl_addr = dl_addr_t'(i);
            ioctl_dout = image[i];
            ioctl_wr   = 1'b1;
            next_cycle();
            ioctl_wr   = 1'b0;
            if ($urandom_range(3) == 0) next_cycle();   // Idle gap
        end
        repeat (3) next_cycle();    // Last word reaches the store
        downloading = 1'b0;
    endtask

    task automatic gfx_read(input logic [GFX_AW-1:0] addr, output int cycles);
        gfx_addr = addr;
        gfx_cs   = 1'b1;
        cycles   = 0;
        do begin
            next_cycle();
            cycles++;
        end while (!gfx_ok);
        gfx_cs = 1'b0;
    endtask

    task automatic snd_read(input logic [SND_AW-1:0] addr, output int cycles);
        snd_addr = addr;
        snd_cs   = 1'b1;
        cycles   = 0;
        do begin
            next_cycle();
            cycles++;
        end while (!snd_ok);
        snd_cs = 1'b0;
    endtask

    task automatic read_both_random();
        rnd = $urandom;
        fork
            gfx_read(rnd[GFX_AW-1:0], gfx_cycles);
            snd_read(rnd[GFX_AW+SND_AW-1:GFX_AW], snd_cycles);
        join
    endtask

    task automatic check_latency(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("ERROR %0t %s latency expected %0d actual %0d", $time, name, expected,
                     actual);
            tb_errors++;
        end
    endtask

    initial begin
        rnd         = $urandom(17);
        tb_errors   = 0;
        arst_n      = 1'b0;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        ioctl_wr    = 1'b0;
        gfx_cs      = 1'b0;
        gfx_addr    = '0;
        snd_cs      = 1'b0;
        snd_addr    = '0;
        repeat (4) @(posedge clk);
        #2 arst_n = 1'b1;
        next_cycle();
        download_image();
        for (int i = 0; i < (1 << GFX_AW); i++) begin
            gfx_read(i[GFX_AW-1:0], gfx_cycles);
            if (gfx_cycles < 3) check_latency("gfx_ok miss", 3, gfx_cycles);
        end
        // Even byte then odd byte of one word, the second is a hit
        for (int i = 0; i < N_RAND; i++) begin
            rnd = $urandom;
            snd_read({rnd[SND_AW-1:1], 1'b0}, snd_cycles);
            snd_read({rnd[SND_AW-1:1], 1'b1}, snd_cycles);
            check_latency("snd_ok", 1, snd_cycles);
        end
        for (int i = 0; i < N_RAND; i++) read_both_random();
        for (int i = 0; i < N_RAND; i++) begin
            rnd = $urandom;
            gfx_read(rnd[GFX_AW-1:0], gfx_cycles);
            next_cycle();
            gfx_read(rnd[GFX_AW-1:0], gfx_cycles);
            check_latency("gfx_ok", 1, gfx_cycles);
        end
        // Requests held through a second download must see the new image
        gfx_cs = 1'b1;
        snd_cs = 1'b1;
        do next_cycle(); while (!(gfx_ok && snd_ok));
        download_image();
        do next_cycle(); while (!(gfx_ok && snd_ok));
        gfx_cs = 1'b0;
        snd_cs = 1'b0;
        for (int i = 0; i < N_RAND; i++) read_both_random();
        repeat (2) next_cycle();
        if (chk_compares == 0) begin
            $display("The checker did not compare any slot result");
            tb_errors++;
        end
        total = tb_errors + chk_errors + i_dut.i_sva.fail_count;
        $display("Error counts: checker %0d, assertions %0d, testbench %0d (%0d compares)",
                 chk_errors, i_dut.i_sva.fail_count, tb_errors, chk_compares);
        if (total == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not complete within %0d ns", TIMEOUT_NS);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- sim.f
source/rom_types_pkg.sv
source/rom_arb_pkg.sv
source/dl_packer.sv
source/rom_store.sv
source/rom_slot_arb.sv
source/rom_subsys.sv
dv/rom_subsys_sva.sv
dv/rom_checker.sv
dv/tb_rom_subsys.sv

//--- source/dl_packer.sv
module dl_packer
    import rom_types_pkg::*;
#(
    parameter bit SWAB = 1'b0
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     downloading,
    input  dl_addr_t ioctl_addr,
    input  byte_t    ioctl_dout,
    input  logic     ioctl_wr,
    output waddr_t   prog_addr,
    output word_t    prog_data,
    output logic     prog_we
);

    byte_t even_byte;   // First half of the word being built
    logic  odd_strobe;
    logic  even_strobe;

    assign even_strobe = downloading && ioctl_wr && !ioctl_addr[0];
    assign odd_strobe  = downloading && ioctl_wr &&  ioctl_addr[0];

    // One write pulse per completed word
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prog_we <= 1'b0;
        end else begin
            prog_we <= odd_strobe;
        end
    end

    always_ff @(posedge clk) begin
        if (even_strobe) begin
            even_byte <= ioctl_dout;
        end
        if (odd_strobe) begin
            prog_addr <= ioctl_addr[$bits(dl_addr_t)-1:1];  // Byte address halved
            if (SWAB) begin
                // Even byte lands in the upper half
                prog_data <= {even_byte, ioctl_dout};
            end else begin
                prog_data <= {ioctl_dout, even_byte};
            end
        end
    end

endmodule

//--- source/rom_arb_pkg.sv
package rom_arb_pkg;

    // Clients of the ROM store
    typedef enum logic {
        SLOT_GFX,   // 16-bit, word addressed
        SLOT_SND    // 8-bit, byte addressed
    } slot_t;

    // Arbiter FSM
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_GFX,    // Read in flight for graphics
        ST_WAIT_SND     // Read in flight for sound
    } arb_state_t;

endpackage

//--- source/rom_slot_arb.sv
module rom_slot_arb
    import rom_types_pkg::*;
    import rom_arb_pkg::*;
#(
    parameter bit SWAB       = 1'b0,
    parameter int GFX_OFFSET = 0,
    parameter int SND_OFFSET = 2048,
    parameter int GFX_AW     = 11,
    parameter int SND_AW     = 11
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              downloading,
    input  logic              gfx_cs,
    input  logic [GFX_AW-1:0] gfx_addr,
    input  logic              snd_cs,
    input  logic [SND_AW-1:0] snd_addr,
    input  word_t             rd_data,
    output word_t             gfx_data,
    output logic              gfx_ok,
    output byte_t             snd_data,
    output logic              snd_ok,
    output logic              rd_en,
    output waddr_t            rd_addr
);

    arb_state_t state;
    slot_t      last_slot;     // Slot served by the previous read

    // Per-slot cache, tags hold the full store address
    word_t  gfx_cache, snd_cache;
    waddr_t gfx_tag,   snd_tag;
    logic   gfx_valid, snd_valid;
    logic   snd_lsb_q;

    waddr_t gfx_waddr, snd_waddr;
    logic   gfx_hit,   snd_hit;
    logic   gfx_miss,  snd_miss;
    logic   pick_gfx,  pick_snd;
    logic   fill_gfx,  fill_snd;

    assign gfx_waddr = waddr_t'(GFX_OFFSET) + waddr_t'(gfx_addr);
    assign snd_waddr = waddr_t'(SND_OFFSET) + waddr_t'(snd_addr[SND_AW-1:1]);  // Byte to word

    assign gfx_hit  = gfx_valid && gfx_tag == gfx_waddr;
    assign snd_hit  = snd_valid && snd_tag == snd_waddr;
    assign gfx_miss = gfx_cs && !gfx_hit;
    assign snd_miss = snd_cs && !snd_hit;

    // On a double miss the slot not served last wins
    assign pick_gfx = state == ST_IDLE && !downloading && gfx_miss &&
                      (!snd_miss || last_slot == SLOT_SND);
    assign pick_snd = state == ST_IDLE && !downloading && snd_miss && !pick_gfx;

    // rd_en high marks the cycle the store is sampling, data follows
    assign fill_gfx = state == ST_WAIT_GFX && !rd_en && !downloading;
    assign fill_snd = state == ST_WAIT_SND && !rd_en && !downloading;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_IDLE;
            last_slot <= SLOT_SND;
            rd_en     <= 1'b0;
            gfx_valid <= 1'b0;
            snd_valid <= 1'b0;
        end else if (downloading) begin
            // Store contents are changing, drop everything
            state     <= ST_IDLE;
            rd_en     <= 1'b0;
            gfx_valid <= 1'b0;
            snd_valid <= 1'b0;
        end else begin
            rd_en <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (pick_gfx) begin
                        rd_en     <= 1'b1;
                        last_slot <= SLOT_GFX;
                        state     <= ST_WAIT_GFX;
                    end else if (pick_snd) begin
                        rd_en     <= 1'b1;
                        last_slot <= SLOT_SND;
                        state     <= ST_WAIT_SND;
                    end
                end
                ST_WAIT_GFX: if (fill_gfx) begin
                    gfx_valid <= 1'b1;
                    state     <= ST_IDLE;
                end
                ST_WAIT_SND: if (fill_snd) begin
                    snd_valid <= 1'b1;
                    state     <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Read address and cache payload
    always_ff @(posedge clk) begin
        if (pick_gfx) begin
            rd_addr <= gfx_waddr;
        end else if (pick_snd) begin
            rd_addr <= snd_waddr;
        end
        if (fill_gfx) begin
            gfx_cache <= rd_data;
            gfx_tag   <= rd_addr;   // Still holds the issued address
        end
        if (fill_snd) begin
            snd_cache <= rd_data;
            snd_tag   <= rd_addr;
        end
        snd_lsb_q <= snd_addr[0];   // Byte select, aligned with snd_ok
    end

    // ok follows the request by one cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            gfx_ok <= 1'b0;
            snd_ok <= 1'b0;
        end else begin
            gfx_ok <= !downloading && gfx_cs && gfx_hit;
            snd_ok <= !downloading && snd_cs && snd_hit;
        end
    end

    assign gfx_data = gfx_cache;
    // Even byte sits high when swapped
    assign snd_data = (snd_lsb_q ^ SWAB) ? snd_cache[15:8] : snd_cache[7:0];

endmodule

//--- source/rom_store.sv
module rom_store
    import rom_types_pkg::*;
(
    input  logic   clk,
    input  logic   prog_we,
    input  waddr_t prog_addr,
    input  word_t  prog_data,
    input  logic   rd_en,
    input  waddr_t rd_addr,
    output word_t  rd_data
);

    localparam int DEPTH = 1 << $bits(waddr_t);

    word_t mem [0:DEPTH-1];    // Stands in for SDRAM

    // Write port, fed by the download packer
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // Registered read, a same-cycle write to the same word returns the old value
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

//--- source/rom_subsys.sv
module rom_subsys
    import rom_types_pkg::*;
#(
    parameter bit SWAB       = 1'b0,
    parameter int GFX_OFFSET = 0,
    parameter int SND_OFFSET = 2048,
    parameter int GFX_AW     = 11,
    parameter int SND_AW     = 11
) (
    input  logic              clk,
    input  logic              arst_n,
    // ROM download
    input  logic              downloading,
    input  dl_addr_t          ioctl_addr,
    input  byte_t             ioctl_dout,
    input  logic              ioctl_wr,
    // Graphics slot
    input  logic              gfx_cs,
    input  logic [GFX_AW-1:0] gfx_addr,
    output word_t             gfx_data,
    output logic              gfx_ok,
    // Sound slot
    input  logic              snd_cs,
    input  logic [SND_AW-1:0] snd_addr,
    output byte_t             snd_data,
    output logic              snd_ok
);

    waddr_t prog_addr, rd_addr;
    word_t  prog_data, rd_data;
    logic   prog_we,   rd_en;

    dl_packer #(.SWAB(SWAB)) u_packer (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .ioctl_wr    ( ioctl_wr    ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_we     ( prog_we     )
    );

    rom_store u_store (
        .clk         ( clk         ),
        .prog_we     ( prog_we     ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .rd_en       ( rd_en       ),
        .rd_addr     ( rd_addr     ),
        .rd_data     ( rd_data     )
    );

    rom_slot_arb #(
        .SWAB        ( SWAB        ),
        .GFX_OFFSET  ( GFX_OFFSET  ),   // Graphics
        .SND_OFFSET  ( SND_OFFSET  ),   // Sound
        .GFX_AW      ( GFX_AW      ),
        .SND_AW      ( SND_AW      )
    ) u_arb (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .gfx_cs      ( gfx_cs      ),
        .gfx_addr    ( gfx_addr    ),
        .snd_cs      ( snd_cs      ),
        .snd_addr    ( snd_addr    ),
        .rd_data     ( rd_data     ),
        .gfx_data    ( gfx_data    ),
        .gfx_ok      ( gfx_ok      ),
        .snd_data    ( snd_data    ),
        .snd_ok      ( snd_ok      ),
        .rd_en       ( rd_en       ),
        .rd_addr     ( rd_addr     )
    );

endmodule

//--- source/rom_types_pkg.sv
package rom_types_pkg;

    // Download stream byte, also the sound slot datum
    typedef logic [7:0] byte_t;

    // Stored word and graphics slot datum
    typedef logic [15:0] word_t;

    // Word address into the 4096-word store
    typedef logic [11:0] waddr_t;

    // Byte address of the download stream
    typedef logic [12:0] dl_addr_t;

endpackage
